/* hw/io_params.svh */
`ifndef IO_PARAMS_SVH
`define IO_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// I/O register addresses on the data bus
////////////////////////////////////////////////////////////////////////////

`define IO_SEG_ADDR    32'hffff_fc00
`define IO_LED_ADDR    32'hffff_fc04
`define IO_BLINK_ADDR  32'hffff_fc08
`define IO_A_ADDR      32'hffff_fc10
`define IO_B_ADDR      32'hffff_fc14
`define IO_TEST_ADDR   32'hffff_fc18

////////////////////////////////////////////////////////////////////////////
// Display queue and dwell
////////////////////////////////////////////////////////////////////////////

// Pointer width, 32 entries
`define IO_QUEUE_AW      5

// Cycles of countdown per displayed word, short for simulation
`define IO_DWELL_CYCLES  32'd12

`endif

/* hw/io_pkg.sv */
package io_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus and display words
  ////////////////////////////////////////////////////////////////////////////

  // Address, store data, load data and memory data
  typedef logic [31:0] io_word_t;

  // One segment display word, also one queue entry
  typedef logic [23:0] seg_word_t;

  // Segment and LED stores carry the word in the low 24 bits
  typedef struct packed {
    logic [7:0] pad;
    seg_word_t  word;
  } io_seg_fmt_t;

  ////////////////////////////////////////////////////////////////////////////
  // Store data as seen by the I/O registers
  ////////////////////////////////////////////////////////////////////////////

  // Same store word, two readings
  // count for the blink register, seg for segment and LED registers
  typedef union packed {
    io_word_t    count;
    io_seg_fmt_t seg;
  } io_wdata_u;

  ////////////////////////////////////////////////////////////////////////////
  // Display dwell machine
  ////////////////////////////////////////////////////////////////////////////

  // IDLE shows nothing, SHOW holds the head word on the outputs
  typedef enum logic {
    IDLE,
    SHOW
  } show_state_e;

endpackage

/* hw/io_bus_decode.sv */
`include "io_params.svh"

module io_bus_decode (
  input  logic                clk,
  input  logic                reset,
  input  logic                io_read,
  input  logic                io_write,
  input  io_pkg::io_word_t    alu_result,
  input  io_pkg::io_wdata_u   store_data,
  input  io_pkg::io_word_t    mem_read_data,
  input  logic [7:0]          io_switch,
  input  logic [2:0]          test_input,
  input  logic                enter_a,
  input  logic                enter_b,
  output logic                seg_write,
  output logic                blink_write,
  output io_pkg::seg_word_t   seg_data,
  output io_pkg::io_word_t    blink_count,
  output io_pkg::io_word_t    mem_io_result,
  output io_pkg::seg_word_t   led_out
);

  logic       led_write;
  logic [7:0] a_reg;
  logic [7:0] b_reg;

  // Store strobes, one address compare
  always_comb begin
    seg_write   = 1'b0;
    led_write   = 1'b0;
    blink_write = 1'b0;
    if (io_write) begin
      case (alu_result)
        `IO_SEG_ADDR:   seg_write   = 1'b1;
        `IO_LED_ADDR:   led_write   = 1'b1;
        `IO_BLINK_ADDR: blink_write = 1'b1;
        default: ;
      endcase
    end
  end

  assign seg_data    = store_data.seg.word;
  assign blink_count = store_data.count;

  // Switch captures and LED register
  always_ff @(posedge clk) begin
    if (reset) begin
      a_reg   <= '0;
      b_reg   <= '0;
      led_out <= '0;
    end else begin
      if (enter_a)   a_reg   <= io_switch;
      if (enter_b)   b_reg   <= io_switch;
      if (led_write) led_out <= store_data.seg.word;
    end
  end

  // Load result, I/O values are zero-extended
  always_comb begin
    mem_io_result = mem_read_data;
    if (io_read) begin
      case (alu_result)
        `IO_A_ADDR:    mem_io_result = {24'b0, a_reg};
        `IO_B_ADDR:    mem_io_result = {24'b0, b_reg};
        `IO_TEST_ADDR: mem_io_result = {29'b0, test_input};
        default: ;
      endcase
    end
  end

endmodule

/* hw/seg_queue.sv */
`include "io_params.svh"

module seg_queue #(
  parameter int addr_bits = `IO_QUEUE_AW
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               push,
  input  io_pkg::seg_word_t  push_data,
  input  logic               pop,
  output io_pkg::seg_word_t  head,
  output logic               empty,
  output logic               full
);

  localparam int depth = 1 << addr_bits;

  io_pkg::seg_word_t    mem [depth];
  logic [addr_bits-1:0] front;
  logic [addr_bits-1:0] back;
  logic [addr_bits:0]   count;
  logic                 do_push;
  logic                 do_pop;

  assign empty = (count == '0);
  assign full  = (count == (addr_bits + 1)'(depth));

  // Overflow drops the new word, underflow is a no-op
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // Entry storage, written at the back end of the list
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[back] <= push_data;
    end
  end

  // Pointers wrap on their own width
  always_ff @(posedge clk) begin
    if (reset) begin
      front <= '0;
      back  <= '0;
      count <= '0;
    end else begin
      if (do_push) back  <= back + 1'b1;
      if (do_pop)  front <= front + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Oldest word
  assign head = mem[front];

endmodule

/* hw/seg_show_fsm.sv */
module seg_show_fsm (
  input  logic               clk,
  input  logic               reset,
  input  logic               empty,
  input  io_pkg::seg_word_t  head,
  input  logic               dwell_busy,
  output logic               pop,
  output logic               dwell_load,
  output io_pkg::seg_word_t  seg_out
);

  io_pkg::show_state_e state;
  io_pkg::show_state_e state_next;

  ////////////////////////////////////////////////////////////////////////////
  // Next state and strobes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    pop        = 1'b0;
    dwell_load = 1'b0;
    case (state)
      io_pkg::IDLE: begin
        // Take the oldest word and start its dwell
        if (!empty) begin
          dwell_load = 1'b1;
          state_next = io_pkg::SHOW;
        end
      end
      io_pkg::SHOW: begin
        // Dwell over, release the word
        if (!dwell_busy) begin
          pop        = 1'b1;
          state_next = io_pkg::IDLE;
        end
      end
      default: begin
        state_next = io_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= io_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Blank between words
  assign seg_out = (state == io_pkg::SHOW) ? head : '0;

endmodule

/* hw/io_timer.sv */
module io_timer (
  input  logic              clk,
  input  logic              reset,
  input  logic              load,
  input  io_pkg::io_word_t  load_value,
  output logic              busy
);

  io_pkg::io_word_t count;

  // Load wins over the countdown
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      count <= load_value;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // High for exactly load_value cycles after a load
  assign busy = (count != '0);

endmodule

/* hw/io_subsystem.sv */
`include "io_params.svh"

module io_subsystem (
  input  logic               clk,
  input  logic               reset,
  input  logic               io_read,
  input  logic               io_write,
  input  io_pkg::io_word_t   alu_result,
  input  io_pkg::io_word_t   store_data,
  input  io_pkg::io_word_t   mem_read_data,
  input  logic [7:0]         io_switch,
  input  logic [2:0]         test_input,
  input  logic               enter_a,
  input  logic               enter_b,
  output io_pkg::io_word_t   mem_io_result,
  output io_pkg::seg_word_t  seg_out,
  output io_pkg::seg_word_t  led_out,
  output logic               blink_out
);

  logic              seg_write;
  logic              blink_write;
  io_pkg::seg_word_t seg_data;
  io_pkg::io_word_t  blink_count;
  io_pkg::seg_word_t head;
  logic              empty;
  logic              full;
  logic              pop;
  logic              dwell_load;
  logic              dwell_busy;

  ////////////////////////////////////////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////////////////////////////////////////

  io_bus_decode u_decode (
    .clk           (clk),
    .reset         (reset),
    .io_read       (io_read),
    .io_write      (io_write),
    .alu_result    (alu_result),
    .store_data    (store_data),
    .mem_read_data (mem_read_data),
    .io_switch     (io_switch),
    .test_input    (test_input),
    .enter_a       (enter_a),
    .enter_b       (enter_b),
    .seg_write     (seg_write),
    .blink_write   (blink_write),
    .seg_data      (seg_data),
    .blink_count   (blink_count),
    .mem_io_result (mem_io_result),
    .led_out       (led_out)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Segment display path
  ////////////////////////////////////////////////////////////////////////////

  seg_queue u_queue (
    .clk       (clk),
    .reset     (reset),
    .push      (seg_write),
    .push_data (seg_data),
    .pop       (pop),
    .head      (head),
    .empty     (empty),
    .full      (full)
  );

  seg_show_fsm u_show (
    .clk        (clk),
    .reset      (reset),
    .empty      (empty),
    .head       (head),
    .dwell_busy (dwell_busy),
    .pop        (pop),
    .dwell_load (dwell_load),
    .seg_out    (seg_out)
  );

  // Fixed dwell per word
  io_timer u_dwell_timer (
    .clk        (clk),
    .reset      (reset),
    .load       (dwell_load),
    .load_value (`IO_DWELL_CYCLES),
    .busy       (dwell_busy)
  );

  // Blink length comes from the store
  io_timer u_blink_timer (
    .clk        (clk),
    .reset      (reset),
    .load       (blink_write),
    .load_value (blink_count),
    .busy       (blink_out)
  );

endmodule

/* tb/io_subsystem_chk.sv */
module io_subsystem_chk (
  input logic                clk,
  input logic                reset,
  input logic                push,
  input logic                pop,
  input logic                empty,
  input logic                full,
  input logic                blink_out,
  input io_pkg::seg_word_t   seg_out,
  input io_pkg::show_state_e state
);

  // Queue underflow never requested by the dwell machine
  a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
    else $error("pop requested while the display queue is empty");

  a_blink_after_reset: assert property (@(posedge clk) reset |=> !blink_out)
    else $error("blink_out high in the cycle after reset");

  // Blank display between words
  a_idle_blank: assert property (@(posedge clk) disable iff (reset)
    (state == io_pkg::IDLE) |-> (seg_out == '0))
    else $error("seg_out nonzero while the dwell machine is idle");

  a_full_drop: assert property (@(posedge clk) disable iff (reset)
    (push && full && !pop) |=> full)
    else $error("push to a full queue changed the full flag");

endmodule

bind io_subsystem io_subsystem_chk u_chk (
  .clk       (clk),
  .reset     (reset),
  .push      (seg_write),
  .pop       (pop),
  .empty     (empty),
  .full      (full),
  .blink_out (blink_out),
  .seg_out   (seg_out),
  .state     (u_show.state)
);

/* tb/io_subsystem_tb.sv */
`include "io_params.svh"

module io_subsystem_tb;

  localparam int QUEUE_DEPTH   = 1 << `IO_QUEUE_AW;
  localparam int DWELL         = `IO_DWELL_CYCLES;
  localparam int TEST_CYCLES   = 40 * (DWELL + 3) + 5 * (DWELL + 3) + 400;
  localparam int WATCHDOG_TIME = 40 * TEST_CYCLES + 4000;

  logic              clk;
  logic              reset;
  logic              io_read;
  logic              io_write;
  io_pkg::io_word_t  alu_result;
  io_pkg::io_word_t  store_data;
  io_pkg::io_word_t  mem_read_data;
  logic [7:0]        io_switch;
  logic [2:0]        test_input;
  logic              enter_a;
  logic              enter_b;
  io_pkg::io_word_t  mem_io_result;
  io_pkg::seg_word_t seg_out;
  io_pkg::seg_word_t led_out;
  logic              blink_out;

  // Cycle model of the I/O block
  io_pkg::seg_word_t m_q[$];
  logic              m_show;
  int                m_left;
  int                m_drops;
  io_pkg::io_word_t  m_blink;
  io_pkg::seg_word_t m_led;
  logic [7:0]        m_a;
  logic [7:0]        m_b;
  int                checks;
  int                errors;

  // Words seen on seg_out, one per nonzero run
  int                shown;
  io_pkg::seg_word_t seg_prev;

  io_subsystem u_io_subsystem (
    .clk           (clk),
    .reset         (reset),
    .io_read       (io_read),
    .io_write      (io_write),
    .alu_result    (alu_result),
    .store_data    (store_data),
    .mem_read_data (mem_read_data),
    .io_switch     (io_switch),
    .test_input    (test_input),
    .enter_a       (enter_a),
    .enter_b       (enter_b),
    .mem_io_result (mem_io_result),
    .seg_out       (seg_out),
    .led_out       (led_out),
    .blink_out     (blink_out)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Expected values and compares
  ////////////////////////////////////////////////////////////////////////////

  function automatic io_pkg::io_word_t io_expect_load(input logic rd,
      input io_pkg::io_word_t addr, input io_pkg::io_word_t mem,
      input logic [7:0] a, input logic [7:0] b, input logic [2:0] t);
    io_pkg::io_word_t r;
    r = mem;
    if (rd && addr == `IO_A_ADDR) r = {24'h0, a};
    else if (rd && addr == `IO_B_ADDR) r = {24'h0, b};
    else if (rd && addr == `IO_TEST_ADDR) r = {29'h0, t};
    return r;
  endfunction

  task automatic check_word(input io_pkg::io_word_t got, input io_pkg::io_word_t exp,
      input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_seg(input io_pkg::seg_word_t got, input io_pkg::seg_word_t exp,
      input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Outputs are stable at the falling edge; model then steps to the next rising edge
  always @(negedge clk) begin : compare_outputs
    io_pkg::io_wdata_u wd;
    io_pkg::seg_word_t exp_seg;
    logic              full_pre;
    wd = store_data;
    if (reset) begin
      m_q.delete();
      m_show   = 1'b0;
      m_left   = 0;
      m_blink  = '0;
      m_led    = '0;
      m_a      = '0;
      m_b      = '0;
      seg_prev = '0;
    end else begin
      exp_seg = '0;
      if (m_show) exp_seg = m_q[0];
      check_seg(seg_out, exp_seg, "seg_out");
      if (seg_out != '0 && seg_prev == '0) shown++;
      seg_prev = seg_out;
      check_seg(led_out, m_led, "led_out");
      check_bit(blink_out, m_blink != '0, "blink_out");
      check_word(mem_io_result,
        io_expect_load(io_read, alu_result, mem_read_data, m_a, m_b, test_input),
        "mem_io_result");
      if (enter_a) m_a = io_switch;
      if (enter_b) m_b = io_switch;
      if (io_write && alu_result == `IO_LED_ADDR) m_led = wd.seg.word;
      if (io_write && alu_result == `IO_BLINK_ADDR) m_blink = wd.count;
      else if (m_blink != '0) m_blink = m_blink - 1;
      full_pre = (m_q.size() == QUEUE_DEPTH);
      // Word shown for DWELL + 1 cycles, then released
      if (m_show) begin
        if (m_left == 0) begin
          void'(m_q.pop_front());
          m_show = 1'b0;
        end else begin
          m_left--;
        end
      end else if (m_q.size() != 0) begin
        m_show = 1'b1;
        m_left = DWELL;
      end
      if (io_write && alu_result == `IO_SEG_ADDR) begin
        if (full_pre) m_drops++;
        else m_q.push_back(wd.seg.word);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_bus(input logic rd, input logic wr, input io_pkg::io_word_t addr,
      input io_pkg::io_word_t data);
    @(posedge clk);
    #2;
    io_read       = rd;
    io_write      = wr;
    alu_result    = addr;
    store_data    = data;
    mem_read_data = $urandom;
    enter_a       = 1'b0;
    enter_b       = 1'b0;
  endtask

  task automatic capture_switch(input logic sel_b, input logic [7:0] value);
    drive_bus(1'b0, 1'b0, $urandom, '0);
    io_switch = value;
    if (sel_b) enter_b = 1'b1;
    else enter_a = 1'b1;
  endtask

  task automatic wait_display_drained();
    while (m_q.size() != 0 || m_show) drive_bus(1'b0, 1'b0, $urandom, '0);
    repeat (2) drive_bus(1'b0, 1'b0, $urandom, '0);
  endtask

  task automatic end_test(input string name, input int start);
    $display("test %-12s finished, %0d mismatches", name, errors - start);
  endtask

  initial begin : stimulus
    int start;
    int n;
    int drops0;
    int shown0;
    void'($urandom(32'hf35a));
    reset         = 1'b1;
    io_read       = 1'b0;
    io_write      = 1'b0;
    alu_result    = '0;
    store_data    = '0;
    mem_read_data = '0;
    io_switch     = '0;
    test_input    = '0;
    enter_a       = 1'b0;
    enter_b       = 1'b0;
    m_drops       = 0;
    shown         = 0;
    checks        = 0;
    errors        = 0;
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;

    start = errors;
    repeat (8) begin
      capture_switch(1'b0, 8'($urandom));
      capture_switch(1'b1, 8'($urandom));
      drive_bus(1'b1, 1'b0, `IO_A_ADDR, '0);
      test_input = 3'($urandom);
      drive_bus(1'b1, 1'b0, `IO_B_ADDR, '0);
      drive_bus(1'b1, 1'b0, `IO_TEST_ADDR, '0);
      drive_bus(1'b1, 1'b0, $urandom, '0);
      drive_bus(1'b0, 1'b0, `IO_A_ADDR, '0);
    end
    end_test("load_path", start);

    // Low byte keeps the words distinct and nonzero
    start  = errors;
    shown0 = shown;
    for (int i = 0; i < 5; i++) drive_bus(1'b0, 1'b1, `IO_SEG_ADDR,
      {8'($urandom), 16'($urandom), 8'(i + 1)});
    wait_display_drained();
    check_word(io_pkg::io_word_t'(shown - shown0), 32'd5, "displayed word count");
    end_test("display", start);

    start  = errors;
    drops0 = m_drops;
    shown0 = shown;
    for (int i = 0; i < 40; i++) drive_bus(1'b0, 1'b1, `IO_SEG_ADDR,
      {8'h0, 16'($urandom), 8'(i + 1)});
    wait_display_drained();
    check_word(io_pkg::io_word_t'(shown - shown0),
      io_pkg::io_word_t'(40 - (m_drops - drops0)), "displayed word count");
    end_test("queue_full", start);

    // Reload halfway through each blink
    start = errors;
    repeat (3) begin
      n = int'($urandom % 20) + 1;
      drive_bus(1'b0, 1'b1, `IO_BLINK_ADDR, n);
      repeat (n / 2) drive_bus(1'b0, 1'b0, $urandom, '0);
      n = int'($urandom % 20) + 1;
      drive_bus(1'b0, 1'b1, `IO_BLINK_ADDR, n);
      repeat (n + 3) drive_bus(1'b0, 1'b0, $urandom, '0);
    end
    end_test("blink", start);

    start = errors;
    repeat (4) begin
      drive_bus(1'b0, 1'b1, `IO_LED_ADDR, $urandom);
      drive_bus(1'b0, 1'b0, $urandom, '0);
      drive_bus(1'b0, 1'b1, `IO_A_ADDR, $urandom);
      drive_bus(1'b0, 1'b1, `IO_B_ADDR, $urandom);
      drive_bus(1'b0, 1'b1, `IO_TEST_ADDR, $urandom);
      repeat (2) drive_bus(1'b0, 1'b0, $urandom, '0);
    end
    end_test("led_decode", start);

    start = errors;
    capture_switch(1'b0, 8'h5a);
    capture_switch(1'b1, 8'ha5);
    drive_bus(1'b0, 1'b1, `IO_LED_ADDR, $urandom);
    drive_bus(1'b0, 1'b1, `IO_BLINK_ADDR, 32'd15);
    drive_bus(1'b0, 1'b1, `IO_SEG_ADDR, 32'h00ab_cdef);
    repeat (3) drive_bus(1'b0, 1'b0, $urandom, '0);
    reset = 1'b1;
    repeat (3) drive_bus(1'b0, 1'b0, $urandom, '0);
    reset = 1'b0;
    drive_bus(1'b1, 1'b0, `IO_A_ADDR, '0);
    drive_bus(1'b1, 1'b0, `IO_B_ADDR, '0);
    repeat (3) drive_bus(1'b0, 1'b0, $urandom, '0);
    end_test("reset", start);

    $display("summary: %0d checks, %0d passed, %0d errors", checks, checks - errors, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_TIME);
    $display("Timeout: the tests did not finish within %0d time units", WATCHDOG_TIME);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* io_subsystem.f */
+incdir+hw
hw/io_pkg.sv
hw/io_bus_decode.sv
hw/seg_queue.sv
hw/seg_show_fsm.sv
hw/io_timer.sv
hw/io_subsystem.sv
tb/io_subsystem_chk.sv
tb/io_subsystem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the I/O subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 \
  --top-module io_subsystem_tb \
  -f io_subsystem.f \
  -o io_subsystem_sim

./obj_dir/io_subsystem_sim > sim.log 2>&1
cat sim.log

if grep -q ">>> FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation passed"
